// ==== hw/wbuf_pkg.sv ====
// sizes are fixed for 32-bit addresses and 8-word lines, which give 8-beat INCR bursts of 4 bytes
package wbuf_pkg;

    // address and data
    localparam int addr_w = 32;
    localparam int word_w = 32;

    // one cache line
    localparam int line_words = 8;
    localparam int line_w = line_words * word_w;

    // queue size
    localparam int depth = 5;
    localparam int count_w = 3;

    // beat index inside a burst
    localparam int beat_w = 3;

    // fixed AXI burst shape, not driven as ports
    localparam logic [7:0] axi_len = 8'(line_words - 1);
    localparam logic [2:0] axi_size = 3'd2;
    localparam logic [1:0] axi_burst = 2'b01;

    // drain FSM
    typedef enum logic [1:0] {
        drain_idle,
        drain_addr,
        drain_data,
        drain_resp
    } drain_state_e;

    // whether the queue can take another line
    typedef enum logic {
        ins_open,
        ins_full
    } insert_state_e;

endpackage

// ==== hw/write_buffer.sv ====
// newest line sits in slot 0; slots at or above count hold stale data
module write_buffer (
    input  logic                                                clk,
    input  logic                                                rstn,

    // line from the cache
    input  logic [wbuf_pkg::addr_w-1:0]                         in_addr,
    input  logic [wbuf_pkg::line_w-1:0]                         in_data,
    input  logic                                                in_valid,
    output logic                                                in_ready,

    // one pulse per completed drain
    input  logic                                                pop,

    // all slots for the query match
    output logic [wbuf_pkg::depth-1:0][wbuf_pkg::addr_w-1:0]    entry_addr,
    output logic [wbuf_pkg::depth-1:0][wbuf_pkg::line_w-1:0]    entry_line,
    output logic [wbuf_pkg::count_w-1:0]                        count,

    // oldest slot for the drain controller
    output logic [wbuf_pkg::addr_w-1:0]                         oldest_addr,
    output logic [wbuf_pkg::line_w-1:0]                         oldest_line,
    output logic                                                not_empty
);

    wbuf_pkg::insert_state_e ins_state;
    logic push;
    logic [wbuf_pkg::count_w-1:0] count_next;
    logic [wbuf_pkg::count_w-1:0] oldest_idx;

    // a full queue still accepts when a pop frees the last slot
    assign in_ready = (ins_state == wbuf_pkg::ins_open) || pop;
    assign push = in_valid && in_ready;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (!push && pop) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

    // registered full flag keeps in_ready off the in_valid path
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ins_state <= wbuf_pkg::ins_open;
        end else if (count_next == wbuf_pkg::count_w'(wbuf_pkg::depth)) begin
            ins_state <= wbuf_pkg::ins_full;
        end else begin
            ins_state <= wbuf_pkg::ins_open;
        end
    end

    // shift down on insert and drop the last slot
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = wbuf_pkg::depth - 1; i > 0; i--) begin
                entry_addr[i] <= entry_addr[i-1];
                entry_line[i] <= entry_line[i-1];
            end
            entry_addr[0] <= in_addr;
            entry_line[0] <= in_data;
        end
    end

    assign not_empty = (count != '0);

    // the drain side ignores slot 0 while empty
    assign oldest_idx = not_empty ? count - 1'b1 : '0;

    assign oldest_addr = entry_addr[oldest_idx];
    assign oldest_line = entry_line[oldest_idx];

endmodule

// ==== hw/wbuf_query_match.sv ====
// combinational lookup; only slots below count take part, and the newest (lowest slot) hit wins
module wbuf_query_match (
    input  logic [wbuf_pkg::depth-1:0][wbuf_pkg::addr_w-1:0]    entry_addr,
    input  logic [wbuf_pkg::depth-1:0][wbuf_pkg::line_w-1:0]    entry_line,
    input  logic [wbuf_pkg::count_w-1:0]                        count,

    input  logic [wbuf_pkg::addr_w-1:0]                         query_addr,
    output logic [wbuf_pkg::line_w-1:0]                         query_data,
    output logic                                                query_hit
);

    logic [wbuf_pkg::depth-1:0] match;

    // stale slots above the count never match
    always_comb begin
        for (int i = 0; i < wbuf_pkg::depth; i++) begin
            match[i] = (i < count) && (entry_addr[i] == query_addr);
        end
    end

    // walk from oldest to newest so the lowest slot overrides
    always_comb begin
        query_hit = 1'b0;
        query_data = '0;
        for (int i = wbuf_pkg::depth - 1; i >= 0; i--) begin
            if (match[i]) begin
                query_hit = 1'b1;
                query_data = entry_line[i];
            end
        end
    end

endmodule

// ==== hw/wbuf_drain_ctrl.sv ====
// one AXI4 write burst per line with fixed len, size and type; one burst in flight at a time
module wbuf_drain_ctrl (
    input  logic                            clk,
    input  logic                            rstn,

    // oldest queue entry
    input  logic                            not_empty,
    input  logic [wbuf_pkg::addr_w-1:0]     oldest_addr,
    input  logic [wbuf_pkg::line_w-1:0]     oldest_line,
    output logic                            pop,

    // AXI write address
    output logic [wbuf_pkg::addr_w-1:0]     awaddr,
    output logic                            awvalid,
    input  logic                            awready,

    // AXI write data
    output logic [wbuf_pkg::word_w-1:0]     wdata,
    output logic                            wlast,
    output logic                            wvalid,
    input  logic                            wready,

    // AXI write response
    input  logic                            bvalid,
    output logic                            bready
);

    wbuf_pkg::drain_state_e state;
    wbuf_pkg::drain_state_e state_next;
    logic [wbuf_pkg::beat_w-1:0] beat;
    logic [wbuf_pkg::addr_w-1:0] addr_q;
    logic [wbuf_pkg::line_w-1:0] line_q;
    logic last_beat;

    assign last_beat = (beat == wbuf_pkg::beat_w'(wbuf_pkg::line_words - 1));

    always_comb begin
        state_next = state;
        case (state)
            wbuf_pkg::drain_idle: begin
                if (not_empty) begin
                    state_next = wbuf_pkg::drain_addr;
                end
            end
            wbuf_pkg::drain_addr: begin
                if (awready) begin
                    state_next = wbuf_pkg::drain_data;
                end
            end
            wbuf_pkg::drain_data: begin
                if (wready && last_beat) begin
                    state_next = wbuf_pkg::drain_resp;
                end
            end
            wbuf_pkg::drain_resp: begin
                if (bvalid) begin
                    state_next = wbuf_pkg::drain_idle;
                end
            end
            default: state_next = wbuf_pkg::drain_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= wbuf_pkg::drain_idle;
            beat <= '0;
        end else begin
            state <= state_next;
            if (state == wbuf_pkg::drain_addr) begin
                beat <= '0;
            end else if (state == wbuf_pkg::drain_data && wready) begin
                beat <= beat + 1'b1;
            end
        end
    end

    // line copy taken when the drain starts
    always_ff @(posedge clk) begin
        if (state == wbuf_pkg::drain_idle && not_empty) begin
            addr_q <= oldest_addr;
            line_q <= oldest_line;
        end
    end

    assign awvalid = (state == wbuf_pkg::drain_addr);
    assign awaddr = addr_q;

    // word 0 goes out first
    assign wvalid = (state == wbuf_pkg::drain_data);
    assign wdata = line_q[beat*wbuf_pkg::word_w +: wbuf_pkg::word_w];
    assign wlast = wvalid && last_beat;

    assign bready = (state == wbuf_pkg::drain_resp);
    assign pop = bready && bvalid;

endmodule

// ==== hw/wbuf_top.sv ====
// cache to AXI4 write buffer; full lines only, no merging, bresp not checked
module wbuf_top (
    input  logic                            clk,
    input  logic                            rstn,

    // cache side
    input  logic [wbuf_pkg::addr_w-1:0]     in_addr,
    input  logic [wbuf_pkg::line_w-1:0]     in_data,
    input  logic                            in_valid,
    output logic                            in_ready,

    // load forwarding
    input  logic [wbuf_pkg::addr_w-1:0]     query_addr,
    output logic [wbuf_pkg::line_w-1:0]     query_data,
    output logic                            query_hit,

    // AXI4 write channels
    output logic [wbuf_pkg::addr_w-1:0]     awaddr,
    output logic                            awvalid,
    input  logic                            awready,
    output logic [wbuf_pkg::word_w-1:0]     wdata,
    output logic                            wlast,
    output logic                            wvalid,
    input  logic                            wready,
    input  logic [1:0]                      bresp,
    input  logic                            bvalid,
    output logic                            bready
);

    logic [wbuf_pkg::depth-1:0][wbuf_pkg::addr_w-1:0] entry_addr;
    logic [wbuf_pkg::depth-1:0][wbuf_pkg::line_w-1:0] entry_line;
    logic [wbuf_pkg::count_w-1:0] count;
    logic [wbuf_pkg::addr_w-1:0] oldest_addr;
    logic [wbuf_pkg::line_w-1:0] oldest_line;
    logic not_empty;
    logic pop;

    write_buffer i_write_buffer (
        .clk         (clk),
        .rstn        (rstn),
        .in_addr     (in_addr),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .pop         (pop),
        .entry_addr  (entry_addr),
        .entry_line  (entry_line),
        .count       (count),
        .oldest_addr (oldest_addr),
        .oldest_line (oldest_line),
        .not_empty   (not_empty)
    );

    wbuf_query_match i_wbuf_query_match (
        .entry_addr (entry_addr),
        .entry_line (entry_line),
        .count      (count),
        .query_addr (query_addr),
        .query_data (query_data),
        .query_hit  (query_hit)
    );

    // bresp has no consumer here
    wbuf_drain_ctrl i_wbuf_drain_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .not_empty   (not_empty),
        .oldest_addr (oldest_addr),
        .oldest_line (oldest_line),
        .pop         (pop),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready)
    );

endmodule

// ==== test/tb_wbuf.sv ====
// run from the project root; the memory model only covers line addresses below 4 KB
module tb_wbuf;

    timeunit 1ns;
    timeprecision 100ps;

    logic clk;
    logic rstn;
    logic [wbuf_pkg::addr_w-1:0] in_addr;
    logic [wbuf_pkg::line_w-1:0] in_data;
    logic in_valid;
    logic in_ready;
    logic [wbuf_pkg::addr_w-1:0] query_addr;
    logic [wbuf_pkg::line_w-1:0] query_data;
    logic query_hit;
    logic [wbuf_pkg::addr_w-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [wbuf_pkg::word_w-1:0] wdata;
    logic wlast;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;

    // parsed commands
    logic [7:0] op_q[$];
    logic [31:0] a_q[$];
    logic [31:0] b_q[$];
    logic [31:0] c_q[$];

    // expected bursts in insertion order and every insert for the memory check
    logic [31:0] exp_addr_q[$];
    logic [31:0] exp_seed_q[$];
    logic [31:0] ins_addr_q[$];
    logic [31:0] ins_seed_q[$];
    logic [31:0] mem [0:1023];

    int seed = 57077;
    int cycle = 0;
    int limit = 0;
    int stall_until = 0;
    int model_count = 0;
    int done_count = 0;
    int beat_cnt = 0;
    logic burst_active = 1'b0;
    logic b_pending = 1'b0;
    logic aw_wait = 1'b0;
    logic [31:0] aw_hold;
    logic [31:0] cur_addr;
    logic [31:0] cur_seed;
    logic [31:0] exp_word;
    logic [31:0] rnd;
    logic pop_now;
    logic exp_ready;
    logic next_awready = 1'b1;
    logic next_wready = 1'b0;
    logic next_bvalid = 1'b0;

    wbuf_top i_wbuf_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_failed();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [255:0] exp,
                                   input logic [255:0] act);
        $display("FAIL at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
        stop_failed();
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        stop_failed();
    endtask

    // word k of a line is seed + k
    function automatic logic [wbuf_pkg::line_w-1:0] make_line(input logic [31:0] base);
        logic [wbuf_pkg::line_w-1:0] line;
        for (int k = 0; k < wbuf_pkg::line_words; k++) begin
            line[k*32 +: 32] = base + k;
        end
        return line;
    endfunction

    task automatic insert_line(input logic [31:0] addr, input logic [31:0] base);
        in_addr = addr;
        in_data = make_line(base);
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic query_line(input logic [31:0] addr, input logic hit, input logic [31:0] base);
        logic [wbuf_pkg::line_w-1:0] exp_data;
        exp_data = hit ? make_line(base) : '0;
        query_addr = addr;
        @(negedge clk);
        assert (query_hit === hit) else report_mismatch("query_hit", hit, query_hit);
        assert (query_data === exp_data) else report_mismatch("query_data", exp_data, query_data);
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drained();
        logic newest;
        logic [31:0] addr;
        while (done_count != ins_addr_q.size()) begin
            @(posedge clk);
            #1;
        end
        // only the last line written to an address survives in memory
        for (int i = 0; i < ins_addr_q.size(); i++) begin
            newest = 1'b1;
            for (int j = i + 1; j < ins_addr_q.size(); j++) begin
                if (ins_addr_q[j] == ins_addr_q[i]) begin
                    newest = 1'b0;
                end
            end
            addr = ins_addr_q[i];
            for (int k = 0; newest && k < wbuf_pkg::line_words; k++) begin
                assert (mem[addr[11:2] + k] === ins_seed_q[i] + k) else
                    report_mismatch("mem", ins_seed_q[i] + k, mem[addr[11:2] + k]);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        assert (cycle <= limit) else report_error("run timed out before the tests ended");
    end

    always @(posedge clk) begin
        #1;
        awready = next_awready;
        wready = next_wready;
        bvalid = next_bvalid;
    end

    // AXI slave and queue model sample mid-cycle for the handshakes at the next edge
    always @(negedge clk) begin
        if (rstn) begin
            // bvalid is only raised while a response is owed
            pop_now = bvalid;
            if (bvalid) begin
                assert (bready === 1'b1) else report_mismatch("bready", 1'b1, bready);
            end
            exp_ready = (model_count < wbuf_pkg::depth) || pop_now;
            assert (in_ready === exp_ready) else report_mismatch("in_ready", exp_ready, in_ready);
            if (aw_wait) begin
                assert (awvalid === 1'b1 && awaddr === aw_hold) else
                    report_error("awvalid dropped or awaddr changed before awready");
            end
            if (awvalid && awready) begin
                assert (!burst_active && !b_pending && exp_addr_q.size() > 0) else
                    report_error("burst started with no line waiting or another burst open");
                cur_addr = exp_addr_q.pop_front();
                cur_seed = exp_seed_q.pop_front();
                assert (awaddr === cur_addr) else report_mismatch("awaddr", cur_addr, awaddr);
                burst_active = 1'b1;
                beat_cnt = 0;
            end
            if (wvalid && wready) begin
                assert (burst_active) else report_error("write beat sent outside a burst");
                exp_word = cur_seed + beat_cnt;
                assert (wdata === exp_word) else report_mismatch("wdata", exp_word, wdata);
                assert (wlast === (beat_cnt == 7)) else
                    report_mismatch("wlast", beat_cnt == 7, wlast);
                mem[cur_addr[11:2] + beat_cnt] = wdata;
                if (beat_cnt == 7) begin
                    burst_active = 1'b0;
                    b_pending = 1'b1;
                end
                beat_cnt = beat_cnt + 1;
            end
            if (pop_now) begin
                b_pending = 1'b0;
                done_count = done_count + 1;
                model_count = model_count - 1;
            end
            if (in_valid && in_ready) begin
                exp_addr_q.push_back(in_addr);
                exp_seed_q.push_back(in_data[31:0]);
                ins_addr_q.push_back(in_addr);
                ins_seed_q.push_back(in_data[31:0]);
                model_count = model_count + 1;
            end
            aw_wait = awvalid && !awready;
            aw_hold = awaddr;
        end
        rnd = $random(seed);
        next_awready = (cycle >= stall_until);
        next_wready = (rnd[1:0] != 2'b00);
        next_bvalid = b_pending && rnd[2];
    end

    initial begin
        int fd;
        int r;
        logic [7:0] op;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] arg_c;
        logic [1023:0] skip_buf;
        rstn = 1'b0;
        in_addr = '0;
        in_data = '0;
        in_valid = 1'b0;
        query_addr = '0;
        awready = 1'b0;
        wready = 1'b0;
        bresp = 2'b00;
        bvalid = 1'b0;
        fd = $fopen("test/wbuf_tests.txt", "r");
        assert (fd != 0) else report_error("cannot open test/wbuf_tests.txt");
        while ($fscanf(fd, " %c", op) == 1) begin
            arg_a = '0;
            arg_b = '0;
            arg_c = '0;
            case (op)
                "#": r = $fgets(skip_buf, fd);
                "I": r = $fscanf(fd, "%h %h", arg_a, arg_b);
                "Q": r = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
                "S": r = $fscanf(fd, "%h", arg_a);
                "W": r = 0;
                default: report_error("unknown command in the test file");
            endcase
            if (op != "#") begin
                op_q.push_back(op);
                a_q.push_back(arg_a);
                b_q.push_back(arg_b);
                c_q.push_back(arg_c);
            end
        end
        $fclose(fd);
        limit = 40 * op_q.size() + 5;

        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        assert (in_ready === 1'b1) else report_mismatch("in_ready", 1'b1, in_ready);
        assert (awvalid === 1'b0) else report_mismatch("awvalid", 1'b0, awvalid);
        assert (wvalid === 1'b0) else report_mismatch("wvalid", 1'b0, wvalid);
        assert (wlast === 1'b0) else report_mismatch("wlast", 1'b0, wlast);
        assert (bready === 1'b0) else report_mismatch("bready", 1'b0, bready);
        @(posedge clk);
        #1;

        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "I": insert_line(a_q[i], b_q[i]);
                "Q": query_line(a_q[i], b_q[i][0], c_q[i]);
                "S": stall_until = cycle + a_q[i];
                "W": wait_drained();
                default: report_error("unknown command in the test file");
            endcase
        end
        assert (exp_addr_q.size() == 0) else report_error("inserted lines were never drained");
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/wbuf_pkg.sv
hw/write_buffer.sv
hw/wbuf_query_match.sv
hw/wbuf_drain_ctrl.sv
hw/wbuf_top.sv
test/tb_wbuf.sv

// ==== test/wbuf_tests.txt ====
# command letter then hex fields: I addr seed | Q addr hit word0 | S stall_cycles | W
# an inserted line holds seed + k in word k; Q expects word0 + k in word k of a hit line
Q 00000100 0 00000000
Q 00000000 0 00000000
S 00000040
I 00000100 11110000
I 00000100 22220000
Q 00000100 1 22220000
Q 00000200 0 00000000
I 00000200 33330000
I 00000300 44440000
I 00000400 55550000
I 00000500 66660000
Q 00000100 1 22220000
Q 00000300 1 44440000
W
Q 00000100 0 00000000
Q 00000500 0 00000000
I 00000600 77770000
I 00000700 88880000
Q 00000700 1 88880000
Q 00000600 1 77770000
I 00000600 99990000
Q 00000600 1 99990000
W
Q 00000600 0 00000000
Q 00000700 0 00000000
